// File: soc_periph_pkg.sv
/* Memory map, register offsets, interrupt positions, reset values
   and APB request and response types of the peripheral subsystem */
package soc_periph_pkg;

    // Bus widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    // Each slave window is 4 KiB
    localparam int WIN_LSB = 12;

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////
    localparam int SLV_SOC_CTRL = 0;
    localparam int SLV_TIMER    = 1;
    localparam int NUM_SLAVES   = 2;

    localparam logic [ADDR_W-1:0] SOC_CTRL_BASE = 32'h1A10_4000;
    localparam logic [ADDR_W-1:0] TIMER_BASE    = 32'h1A10_B000;

    // SoC control word offsets
    localparam logic [WIN_LSB-1:0] REG_INFO         = 12'h000;
    localparam logic [WIN_LSB-1:0] REG_BOOTADDR     = 12'h004;
    localparam logic [WIN_LSB-1:0] REG_FETCH_EN     = 12'h008;
    localparam logic [WIN_LSB-1:0] REG_CLUSTER_CTRL = 12'h00C;
    localparam logic [WIN_LSB-1:0] REG_JTAG         = 12'h010;
    localparam logic [WIN_LSB-1:0] REG_BOOTSEL      = 12'h014;

    // Timer word offsets
    localparam logic [WIN_LSB-1:0] TMR_CTRL  = 12'h000;
    localparam logic [WIN_LSB-1:0] TMR_COUNT = 12'h004;
    localparam logic [WIN_LSB-1:0] TMR_CMP   = 12'h008;

    // Fields of the INFO word and reset values
    localparam logic [15:0]       NB_CORES     = 16'd4;
    localparam logic [15:0]       NB_CLUSTERS  = 16'd1;
    localparam logic [DATA_W-1:0] BOOTADDR_RST = 32'h1A00_0080;

    // Fabric controller interrupt bit positions
    localparam int IRQ_DMA_EVT  = 8;
    localparam int IRQ_DMA_IRQ  = 9;
    localparam int IRQ_TIMER    = 10;
    localparam int IRQ_PF_EVT   = 12;
    localparam int IRQ_REF_EDGE = 14;

    ////////////////////////////////////////
    // APB types
    ////////////////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              pwrite;
        logic              psel;
        logic              penable;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_resp_t;

endpackage

// File: apb_periph_demux.sv
/* APB address decoder, request fan-out and response mux with an
   error response for unmapped addresses */
`timescale 1ns/1ns

module apb_periph_demux (
    input  logic                                                       clk_i,
    input  logic                                                       rst_ni,
    input  soc_periph_pkg::apb_req_t                                   apb_req_i,
    output soc_periph_pkg::apb_resp_t                                  apb_resp_o,
    output soc_periph_pkg::apb_req_t  [soc_periph_pkg::NUM_SLAVES-1:0] slv_req_o,
    input  soc_periph_pkg::apb_resp_t [soc_periph_pkg::NUM_SLAVES-1:0] slv_resp_i
);

    logic [soc_periph_pkg::ADDR_W-1:soc_periph_pkg::WIN_LSB] addr_tag;
    logic [soc_periph_pkg::NUM_SLAVES-1:0]                    slv_hit;

    assign addr_tag = apb_req_i.paddr[soc_periph_pkg::ADDR_W-1:soc_periph_pkg::WIN_LSB];

    // Window match on the upper address bits
    always_comb begin
        slv_hit = '0;
        slv_hit[soc_periph_pkg::SLV_SOC_CTRL] =
            (addr_tag == soc_periph_pkg::SOC_CTRL_BASE[soc_periph_pkg::ADDR_W-1:
                                                        soc_periph_pkg::WIN_LSB]);
        slv_hit[soc_periph_pkg::SLV_TIMER] =
            (addr_tag == soc_periph_pkg::TIMER_BASE[soc_periph_pkg::ADDR_W-1:
                                                     soc_periph_pkg::WIN_LSB]);
    end

    // Every slave sees the request, only the selected one gets psel
    always_comb begin
        for (int i = 0; i < soc_periph_pkg::NUM_SLAVES; i++) begin
            slv_req_o[i]      = apb_req_i;
            slv_req_o[i].psel = apb_req_i.psel & slv_hit[i];
        end
    end

    // Unmapped address answers at once with an error
    always_comb begin
        apb_resp_o.prdata  = '0;
        apb_resp_o.pready  = 1'b1;
        apb_resp_o.pslverr = apb_req_i.psel & apb_req_i.penable;
        for (int i = 0; i < soc_periph_pkg::NUM_SLAVES; i++) begin
            if (slv_hit[i]) begin
                apb_resp_o = slv_resp_i[i];
            end
        end
    end

    ////////////////////////////////////////
    // Protocol check
    ////////////////////////////////////////
    // Access phase must follow a cycle with psel
    penable_after_psel: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        apb_req_i.penable |-> $past(apb_req_i.psel)
    ) else $error("penable without a preceding setup cycle");

endmodule

// File: soc_ctrl_regs.sv
/* SoC control and status registers: boot address, fetch enable,
   cluster reset request, JTAG exchange, INFO and BOOTSEL */
`timescale 1ns/1ns

module soc_ctrl_regs (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  soc_periph_pkg::apb_req_t  apb_req_i,
    output soc_periph_pkg::apb_resp_t apb_resp_o,
    input  logic [7:0]                jtag_reg_i,
    input  logic [1:0]                bootsel_i,
    input  logic                      clksel_i,
    input  logic                      fetch_en_valid_i,
    input  logic                      fetch_en_i,
    output logic [31:0]               bootaddr_o,
    output logic                      fetch_en_o,
    output logic                      cluster_rstn_req_o,
    output logic [7:0]                jtag_reg_o
);

    logic                               access;
    logic [soc_periph_pkg::WIN_LSB-1:0] offset;
    logic                               valid_off;
    logic                               rd_only;
    logic                               err;
    logic                               wr_en;
    logic [soc_periph_pkg::DATA_W-1:0]  rdata;
    logic [31:0]                        bootaddr_q;
    logic                               fetch_en_q;
    logic                               cluster_q;
    logic [7:0]                         jtag_q;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign offset = apb_req_i.paddr[soc_periph_pkg::WIN_LSB-1:0];

    ////////////////////////////////////////
    // Read decode
    ////////////////////////////////////////
    always_comb begin
        valid_off = 1'b1;
        rd_only   = 1'b0;
        rdata     = '0;
        case (offset)
            soc_periph_pkg::REG_INFO: begin
                rdata   = {soc_periph_pkg::NB_CLUSTERS, soc_periph_pkg::NB_CORES};
                rd_only = 1'b1;
            end
            soc_periph_pkg::REG_BOOTADDR:     rdata = bootaddr_q;
            soc_periph_pkg::REG_FETCH_EN:     rdata = {31'b0, fetch_en_q};
            soc_periph_pkg::REG_CLUSTER_CTRL: rdata = {31'b0, cluster_q};
            // Input byte above, output byte below
            soc_periph_pkg::REG_JTAG:         rdata = {16'b0, jtag_reg_i, jtag_q};
            soc_periph_pkg::REG_BOOTSEL: begin
                rdata   = {29'b0, clksel_i, bootsel_i};
                rd_only = 1'b1;
            end
            default: valid_off = 1'b0;
        endcase
    end

    assign err   = access & (~valid_off | (apb_req_i.pwrite & rd_only));
    assign wr_en = access & apb_req_i.pwrite & ~err;

    assign apb_resp_o.prdata  = err ? '0 : rdata;
    assign apb_resp_o.pready  = 1'b1;
    assign apb_resp_o.pslverr = err;

    ////////////////////////////////////////
    // Register write
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            bootaddr_q <= soc_periph_pkg::BOOTADDR_RST;
            fetch_en_q <= 1'b0;
            cluster_q  <= 1'b0;
            jtag_q     <= '0;
        end else begin
            if (wr_en && offset == soc_periph_pkg::REG_BOOTADDR) begin
                bootaddr_q <= apb_req_i.pwdata;
            end
            // Hardware load wins over a bus write
            if (fetch_en_valid_i) begin
                fetch_en_q <= fetch_en_i;
            end else if (wr_en && offset == soc_periph_pkg::REG_FETCH_EN) begin
                fetch_en_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && offset == soc_periph_pkg::REG_CLUSTER_CTRL) begin
                cluster_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && offset == soc_periph_pkg::REG_JTAG) begin
                jtag_q <= apb_req_i.pwdata[7:0];
            end
        end
    end

    assign bootaddr_o         = bootaddr_q;
    assign fetch_en_o         = fetch_en_q;
    assign cluster_rstn_req_o = cluster_q;
    assign jtag_reg_o         = jtag_q;

    // Request holds still from the setup cycle into the access phase
    req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        access |-> ($stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite) &&
                    $stable(apb_req_i.pwdata))
    ) else $error("soc_ctrl_regs request changed in the access phase");

endmodule

// File: fc_timer.sv
/* Compare timer with APB registers and a one-cycle interrupt pulse */
`timescale 1ns/1ns

module fc_timer (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  soc_periph_pkg::apb_req_t  apb_req_i,
    output soc_periph_pkg::apb_resp_t apb_resp_o,
    output logic                      irq_o
);

    logic                               access;
    logic [soc_periph_pkg::WIN_LSB-1:0] offset;
    logic                               valid_off;
    logic                               err;
    logic                               wr_en;
    logic [soc_periph_pkg::DATA_W-1:0]  rdata;
    logic                               en_q;
    logic [31:0]                        count_q;
    logic [31:0]                        cmp_q;
    logic                               irq_q;
    logic                               cnt_hit;
    logic                               match;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign offset = apb_req_i.paddr[soc_periph_pkg::WIN_LSB-1:0];

    always_comb begin
        valid_off = 1'b1;
        rdata     = '0;
        case (offset)
            soc_periph_pkg::TMR_CTRL:  rdata = {31'b0, en_q};
            soc_periph_pkg::TMR_COUNT: rdata = count_q;
            soc_periph_pkg::TMR_CMP:   rdata = cmp_q;
            default:                   valid_off = 1'b0;
        endcase
    end

    assign err   = access & ~valid_off;
    assign wr_en = access & apb_req_i.pwrite & ~err;

    assign apb_resp_o.prdata  = err ? '0 : rdata;
    assign apb_resp_o.pready  = 1'b1;
    assign apb_resp_o.pslverr = err;

    ////////////////////////////////////////
    // Counter and compare
    ////////////////////////////////////////
    assign cnt_hit = en_q && (count_q == cmp_q);
    // No match in the pulse cycle, so CMP = 0 still gives separate pulses
    assign match   = cnt_hit && !irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q    <= 1'b0;
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            if (wr_en && offset == soc_periph_pkg::TMR_CTRL) begin
                en_q <= apb_req_i.pwdata[0];
            end
            if (wr_en && offset == soc_periph_pkg::TMR_CMP) begin
                cmp_q <= apb_req_i.pwdata;
            end
            if (wr_en && offset == soc_periph_pkg::TMR_COUNT) begin
                count_q <= apb_req_i.pwdata;
            end else if (match) begin
                count_q <= '0;
            end else if (en_q && !cnt_hit) begin
                count_q <= count_q + 32'd1;
            end
            irq_q <= match;
        end
    end

    assign irq_o = irq_q;

endmodule

// File: fc_irq_map.sv
/* Reference clock synchronizer, edge detector and assembly of the
   fabric controller interrupt vector */
`timescale 1ns/1ns

module fc_irq_map (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        slow_clk_i,
    input  logic        timer_irq_i,
    input  logic        dma_pe_evt_i,
    input  logic        dma_pe_irq_i,
    input  logic        pf_evt_i,
    output logic [31:0] fc_interrupts_o
);

    logic [1:0] ref_sync_q;
    logic       ref_last_q;
    logic       ref_edge;

    // Slow clock is only sampled as data here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ref_sync_q <= '0;
            ref_last_q <= 1'b0;
        end else begin
            ref_sync_q <= {ref_sync_q[0], slow_clk_i};
            ref_last_q <= ref_sync_q[1];
        end
    end

    // Rise or fall gives one pulse
    assign ref_edge = ref_sync_q[1] ^ ref_last_q;

    ////////////////////////////////////////
    // Interrupt vector
    ////////////////////////////////////////
    always_comb begin
        fc_interrupts_o = '0;
        fc_interrupts_o[soc_periph_pkg::IRQ_DMA_EVT]  = dma_pe_evt_i;
        fc_interrupts_o[soc_periph_pkg::IRQ_DMA_IRQ]  = dma_pe_irq_i;
        fc_interrupts_o[soc_periph_pkg::IRQ_TIMER]    = timer_irq_i;
        fc_interrupts_o[soc_periph_pkg::IRQ_PF_EVT]   = pf_evt_i;
        fc_interrupts_o[soc_periph_pkg::IRQ_REF_EDGE] = ref_edge;
    end

endmodule

// File: soc_peripherals.sv
/* Peripheral subsystem top: APB decoder, SoC control registers,
   compare timer and interrupt mapper */
`timescale 1ns/1ns

module soc_peripherals (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  soc_periph_pkg::apb_req_t  apb_req_i,
    output soc_periph_pkg::apb_resp_t apb_resp_o,
    input  logic                      slow_clk_i,
    input  logic [1:0]                bootsel_i,
    input  logic                      sel_pll_clk_i,
    input  logic [7:0]                soc_jtag_reg_i,
    input  logic                      fc_fetch_en_valid_i,
    input  logic                      fc_fetch_en_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      dma_pe_irq_i,
    input  logic                      pf_evt_i,
    output logic [31:0]               fc_bootaddr_o,
    output logic                      fc_fetchen_o,
    output logic                      cluster_rstn_req_o,
    output logic [7:0]                soc_jtag_reg_o,
    output logic [31:0]               fc_interrupts_o
);

    soc_periph_pkg::apb_req_t  [soc_periph_pkg::NUM_SLAVES-1:0] slv_req;
    soc_periph_pkg::apb_resp_t [soc_periph_pkg::NUM_SLAVES-1:0] slv_resp;
    logic                                                       timer_irq;

    apb_periph_demux apb_periph_demux_inst (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .apb_req_i  ( apb_req_i  ),
        .apb_resp_o ( apb_resp_o ),
        .slv_req_o  ( slv_req    ),
        .slv_resp_i ( slv_resp   )
    );

    soc_ctrl_regs soc_ctrl_regs_inst (
        .clk_i              ( clk_i                                   ),
        .rst_ni             ( rst_ni                                  ),
        .apb_req_i          ( slv_req[soc_periph_pkg::SLV_SOC_CTRL]   ),
        .apb_resp_o         ( slv_resp[soc_periph_pkg::SLV_SOC_CTRL]  ),
        .jtag_reg_i         ( soc_jtag_reg_i                          ),
        .bootsel_i          ( bootsel_i                               ),
        .clksel_i           ( sel_pll_clk_i                           ),
        .fetch_en_valid_i   ( fc_fetch_en_valid_i                     ),
        .fetch_en_i         ( fc_fetch_en_i                           ),
        .bootaddr_o         ( fc_bootaddr_o                           ),
        .fetch_en_o         ( fc_fetchen_o                            ),
        .cluster_rstn_req_o ( cluster_rstn_req_o                      ),
        .jtag_reg_o         ( soc_jtag_reg_o                          )
    );

    fc_timer fc_timer_inst (
        .clk_i      ( clk_i                                ),
        .rst_ni     ( rst_ni                               ),
        .apb_req_i  ( slv_req[soc_periph_pkg::SLV_TIMER]   ),
        .apb_resp_o ( slv_resp[soc_periph_pkg::SLV_TIMER]  ),
        .irq_o      ( timer_irq                            )
    );

    fc_irq_map fc_irq_map_inst (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .slow_clk_i      ( slow_clk_i      ),
        .timer_irq_i     ( timer_irq       ),
        .dma_pe_evt_i    ( dma_pe_evt_i    ),
        .dma_pe_irq_i    ( dma_pe_irq_i    ),
        .pf_evt_i        ( pf_evt_i        ),
        .fc_interrupts_o ( fc_interrupts_o )
    );

endmodule

// File: tb_soc_peripherals.sv
/* Testbench for the peripheral subsystem: clock, reset, APB driver,
   transaction table and checks of registers, timer and interrupt map */
`timescale 1ns/1ns

module tb_soc_peripherals;

    localparam int SIDE_NONE    = 0;
    localparam int SIDE_BOOT    = 1;
    localparam int SIDE_FETCH   = 2;
    localparam int SIDE_CLUSTER = 3;
    localparam int SIDE_JTAG    = 4;

    localparam int PREADY_TIMEOUT = 16;
    localparam int IRQ_TIMEOUT    = 64;
    localparam int EDGE_TIMEOUT   = 6;

    logic                      clk_i;
    logic                      rst_ni;
    soc_periph_pkg::apb_req_t  apb_req;
    soc_periph_pkg::apb_resp_t apb_resp;
    logic                      slow_clk_i;
    logic [1:0]                bootsel_i;
    logic                      sel_pll_clk_i;
    logic [7:0]                soc_jtag_reg_i;
    logic                      fc_fetch_en_valid_i;
    logic                      fc_fetch_en_i;
    logic                      dma_pe_evt_i;
    logic                      dma_pe_irq_i;
    logic                      pf_evt_i;
    logic [31:0]               fc_bootaddr_o;
    logic                      fc_fetchen_o;
    logic                      cluster_rstn_req_o;
    logic [7:0]                soc_jtag_reg_o;
    logic [31:0]               fc_interrupts_o;

    // Transaction table
    string       t_name[$];
    logic        t_write[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_wdata[$];
    logic [31:0] t_rdata[$];
    logic        t_err[$];
    int          t_side[$];
    logic [31:0] t_side_exp[$];

    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] rnd_boot;
    logic [31:0] rnd_word;
    logic [7:0]  rnd_jtag;
    logic [31:0] rnd_cmp;
    logic [31:0] rdata;
    logic        rerr;
    logic        seen;
    int          cnt;

    soc_peripherals soc_peripherals_inst (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .apb_req_i           ( apb_req             ),
        .apb_resp_o          ( apb_resp            ),
        .slow_clk_i          ( slow_clk_i          ),
        .bootsel_i           ( bootsel_i           ),
        .sel_pll_clk_i       ( sel_pll_clk_i       ),
        .soc_jtag_reg_i      ( soc_jtag_reg_i      ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .dma_pe_evt_i        ( dma_pe_evt_i        ),
        .dma_pe_irq_i        ( dma_pe_irq_i        ),
        .pf_evt_i            ( pf_evt_i            ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .cluster_rstn_req_o  ( cluster_rstn_req_o  ),
        .soc_jtag_reg_o      ( soc_jtag_reg_o      ),
        .fc_interrupts_o     ( fc_interrupts_o     )
    );

    always #4 clk_i = ~clk_i;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] soc_addr(input logic [11:0] off);
        return soc_periph_pkg::SOC_CTRL_BASE | {20'h0, off};
    endfunction

    function automatic logic [31:0] tmr_addr(input logic [11:0] off);
        return soc_periph_pkg::TIMER_BASE | {20'h0, off};
    endfunction

    function automatic logic [31:0] side_value(input int sel);
        case (sel)
            SIDE_BOOT:    return fc_bootaddr_o;
            SIDE_FETCH:   return {31'b0, fc_fetchen_o};
            SIDE_CLUSTER: return {31'b0, cluster_rstn_req_o};
            SIDE_JTAG:    return {24'b0, soc_jtag_reg_o};
            default:      return '0;
        endcase
    endfunction

    task automatic check_eq(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL %s %s expected 0x%08h actual 0x%08h", name, what, exp, got);
            err_cnt++;
        end
    endtask

    task automatic begin_test();
        err_mark = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("ok   %s", name);
        end else begin
            fail_cnt++;
            $display("bad  %s (%0d mismatches)", name, err_cnt - err_mark);
        end
    endtask

    task automatic add_txn(input string name, input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic exp_err, input int side, input logic [31:0] side_exp);
        t_name.push_back(name);
        t_write.push_back(wr);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_rdata.push_back(exp);
        t_err.push_back(exp_err);
        t_side.push_back(side);
        t_side_exp.push_back(side_exp);
    endtask

    // Setup cycle, access cycle until pready, then back to idle
    task automatic apb_xfer(input string name, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rd,
                            output logic err);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk_i);
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk_i);
        apb_req.penable = 1'b1;
        #1;
        while (!apb_resp.pready && wait_cnt < PREADY_TIMEOUT) begin
            wait_cnt++;
            @(negedge clk_i);
            #1;
        end
        assert (apb_resp.pready) else begin
            $display("%s: no pready within %0d cycles", name, PREADY_TIMEOUT);
            err_cnt++;
        end
        rd  = apb_resp.prdata;
        err = apb_resp.pslverr;
        @(negedge clk_i);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apply_txn(input int i);
        logic [31:0] rd;
        logic        err;
        begin_test();
        apb_xfer(t_name[i], t_write[i], t_addr[i], t_wdata[i], rd, err);
        // Write data phase carries no read data unless it is an error
        if (!t_write[i] || t_err[i]) begin
            check_eq(t_name[i], "prdata", t_rdata[i], rd);
        end
        check_eq(t_name[i], "pslverr", {31'b0, t_err[i]}, {31'b0, err});
        if (t_side[i] != SIDE_NONE) begin
            check_eq(t_name[i], "side output", t_side_exp[i], side_value(t_side[i]));
        end
        end_test(t_name[i]);
    endtask

    task automatic check_irq_source(input string name, input int src, input int pos);
        @(negedge clk_i);
        case (src)
            0: dma_pe_evt_i = 1'b1;
            1: dma_pe_irq_i = 1'b1;
            default: pf_evt_i = 1'b1;
        endcase
        #1;
        check_eq(name, "vector", 32'h1 << pos, fc_interrupts_o);
        @(negedge clk_i);
        dma_pe_evt_i = 1'b0;
        dma_pe_irq_i = 1'b0;
        pf_evt_i     = 1'b0;
        #1;
        check_eq(name, "vector idle", 32'h0, fc_interrupts_o);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        clk_i               = 1'b0;
        rst_ni              = 1'b0;
        apb_req             = '0;
        slow_clk_i          = 1'b0;
        fc_fetch_en_valid_i = 1'b0;
        fc_fetch_en_i       = 1'b0;
        dma_pe_evt_i        = 1'b0;
        dma_pe_irq_i        = 1'b0;
        pf_evt_i            = 1'b0;
        err_cnt             = 0;
        err_mark            = 0;
        pass_cnt            = 0;
        fail_cnt            = 0;

        void'($urandom(55809));
        rnd_boot       = $urandom;
        rnd_word       = $urandom;
        rnd_jtag       = rnd_word[7:0];
        soc_jtag_reg_i = rnd_word[15:8];
        bootsel_i      = rnd_word[17:16];
        sel_pll_clk_i  = rnd_word[18];
        rnd_cmp        = $urandom_range(12, 5);

        // Reset values
        add_txn("info_rst", 1'b0, soc_addr(soc_periph_pkg::REG_INFO), '0,
                {soc_periph_pkg::NB_CLUSTERS, soc_periph_pkg::NB_CORES}, 1'b0, SIDE_NONE, '0);
        add_txn("bootaddr_rst", 1'b0, soc_addr(soc_periph_pkg::REG_BOOTADDR), '0,
                soc_periph_pkg::BOOTADDR_RST, 1'b0, SIDE_BOOT, soc_periph_pkg::BOOTADDR_RST);
        add_txn("fetch_en_rst", 1'b0, soc_addr(soc_periph_pkg::REG_FETCH_EN), '0,
                '0, 1'b0, SIDE_FETCH, '0);
        add_txn("cluster_rst", 1'b0, soc_addr(soc_periph_pkg::REG_CLUSTER_CTRL), '0,
                '0, 1'b0, SIDE_CLUSTER, '0);
        // Read and write registers with bit 0 forced high so the 1-bit ones change
        add_txn("bootaddr_wr", 1'b1, soc_addr(soc_periph_pkg::REG_BOOTADDR), rnd_boot,
                '0, 1'b0, SIDE_BOOT, rnd_boot);
        add_txn("bootaddr_rd", 1'b0, soc_addr(soc_periph_pkg::REG_BOOTADDR), '0,
                rnd_boot, 1'b0, SIDE_BOOT, rnd_boot);
        add_txn("fetch_en_wr", 1'b1, soc_addr(soc_periph_pkg::REG_FETCH_EN), $urandom | 32'h1,
                '0, 1'b0, SIDE_FETCH, 32'h1);
        add_txn("fetch_en_rd", 1'b0, soc_addr(soc_periph_pkg::REG_FETCH_EN), '0,
                32'h1, 1'b0, SIDE_FETCH, 32'h1);
        add_txn("cluster_wr", 1'b1, soc_addr(soc_periph_pkg::REG_CLUSTER_CTRL),
                $urandom | 32'h1, '0, 1'b0, SIDE_CLUSTER, 32'h1);
        add_txn("cluster_rd", 1'b0, soc_addr(soc_periph_pkg::REG_CLUSTER_CTRL), '0,
                32'h1, 1'b0, SIDE_CLUSTER, 32'h1);
        // JTAG write data carries the inverted input byte in bits 15 to 8
        add_txn("jtag_wr", 1'b1, soc_addr(soc_periph_pkg::REG_JTAG),
                {rnd_word[31:16], ~soc_jtag_reg_i, rnd_jtag},
                '0, 1'b0, SIDE_JTAG, {24'b0, rnd_jtag});
        add_txn("jtag_rd", 1'b0, soc_addr(soc_periph_pkg::REG_JTAG), '0,
                {16'b0, soc_jtag_reg_i, rnd_jtag}, 1'b0, SIDE_JTAG, {24'b0, rnd_jtag});
        add_txn("bootsel_rd", 1'b0, soc_addr(soc_periph_pkg::REG_BOOTSEL), '0,
                {29'b0, sel_pll_clk_i, bootsel_i}, 1'b0, SIDE_NONE, '0);
        // Error responses leave the registers alone
        add_txn("unmapped_rd", 1'b0, 32'h1A10_0000, '0, '0, 1'b1, SIDE_NONE, '0);
        add_txn("unmapped_wr", 1'b1, 32'h1A10_0004, $urandom, '0, 1'b1, SIDE_BOOT, rnd_boot);
        add_txn("undef_off_rd", 1'b0, soc_addr(12'h040), '0, '0, 1'b1, SIDE_NONE, '0);
        add_txn("undef_off_wr", 1'b1, soc_addr(12'h040), $urandom, '0, 1'b1, SIDE_BOOT, rnd_boot);
        add_txn("info_wr", 1'b1, soc_addr(soc_periph_pkg::REG_INFO), $urandom,
                '0, 1'b1, SIDE_NONE, '0);
        add_txn("info_after_err", 1'b0, soc_addr(soc_periph_pkg::REG_INFO), '0,
                {soc_periph_pkg::NB_CLUSTERS, soc_periph_pkg::NB_CORES}, 1'b0, SIDE_NONE, '0);
        add_txn("bootsel_wr", 1'b1, soc_addr(soc_periph_pkg::REG_BOOTSEL), $urandom,
                '0, 1'b1, SIDE_NONE, '0);
        add_txn("bootaddr_after_err", 1'b0, soc_addr(soc_periph_pkg::REG_BOOTADDR), '0,
                rnd_boot, 1'b0, SIDE_BOOT, rnd_boot);
        add_txn("timer_undef_off", 1'b0, tmr_addr(12'h00C), '0, '0, 1'b1, SIDE_NONE, '0);
        // Timer setup with the enable as the last entry
        add_txn("timer_count_idle", 1'b0, tmr_addr(soc_periph_pkg::TMR_COUNT), '0,
                '0, 1'b0, SIDE_NONE, '0);
        add_txn("timer_cmp_wr", 1'b1, tmr_addr(soc_periph_pkg::TMR_CMP), rnd_cmp,
                '0, 1'b0, SIDE_NONE, '0);
        add_txn("timer_cmp_rd", 1'b0, tmr_addr(soc_periph_pkg::TMR_CMP), '0,
                rnd_cmp, 1'b0, SIDE_NONE, '0);
        add_txn("timer_enable", 1'b1, tmr_addr(soc_periph_pkg::TMR_CTRL), 32'h1,
                '0, 1'b0, SIDE_NONE, '0);

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        begin_test();
        #1;
        check_eq("rst_outputs", "fc_bootaddr_o", soc_periph_pkg::BOOTADDR_RST, fc_bootaddr_o);
        check_eq("rst_outputs", "fc_fetchen_o", 32'h0, {31'b0, fc_fetchen_o});
        check_eq("rst_outputs", "cluster_rstn_req_o", 32'h0, {31'b0, cluster_rstn_req_o});
        check_eq("rst_outputs", "soc_jtag_reg_o", 32'h0, {24'b0, soc_jtag_reg_o});
        check_eq("rst_outputs", "fc_interrupts_o", 32'h0, fc_interrupts_o);
        end_test("rst_outputs");

        for (int i = 0; i < t_name.size(); i++) begin
            apply_txn(i);
        end

        ////////////////////////////////////////
        // Timer interrupt
        ////////////////////////////////////////
        begin_test();
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < IRQ_TIMEOUT) begin
            @(negedge clk_i);
            seen = fc_interrupts_o[soc_periph_pkg::IRQ_TIMER];
            cnt++;
        end
        assert (seen) else begin
            $display("timer_irq: no pulse on bit 10 within %0d cycles", IRQ_TIMEOUT);
            err_cnt++;
        end
        @(negedge clk_i);
        check_eq("timer_irq", "bit 10 after pulse", 32'h0,
                 {31'b0, fc_interrupts_o[soc_periph_pkg::IRQ_TIMER]});
        apb_xfer("timer_count", 1'b0, tmr_addr(soc_periph_pkg::TMR_COUNT), '0, rdata, rerr);
        assert (rdata < rnd_cmp && !rerr) else begin
            $display("FAIL timer_count expected below 0x%08h actual 0x%08h", rnd_cmp, rdata);
            err_cnt++;
        end
        apb_xfer("timer_disable", 1'b1, tmr_addr(soc_periph_pkg::TMR_CTRL), '0, rdata, rerr);
        end_test("timer_irq");

        // Hardware load of fetch enable
        begin_test();
        @(negedge clk_i);
        fc_fetch_en_i       = 1'b0;
        fc_fetch_en_valid_i = 1'b1;
        @(negedge clk_i);
        fc_fetch_en_valid_i = 1'b0;
        check_eq("fetch_en_load", "fc_fetchen_o", 32'h0, {31'b0, fc_fetchen_o});
        apb_xfer("fetch_en_load", 1'b0, soc_addr(soc_periph_pkg::REG_FETCH_EN), '0, rdata, rerr);
        check_eq("fetch_en_load", "prdata", 32'h0, rdata);
        end_test("fetch_en_load");

        ////////////////////////////////////////
        // Interrupt map
        ////////////////////////////////////////
        begin_test();
        check_irq_source("irq_dma_evt", 0, soc_periph_pkg::IRQ_DMA_EVT);
        check_irq_source("irq_dma_irq", 1, soc_periph_pkg::IRQ_DMA_IRQ);
        check_irq_source("irq_pf_evt", 2, soc_periph_pkg::IRQ_PF_EVT);
        end_test("irq_sources");

        begin_test();
        // Rise then fall of the reference clock
        for (int e = 0; e < 2; e++) begin
            @(negedge clk_i);
            slow_clk_i = ~slow_clk_i;
            seen = 1'b0;
            cnt  = 0;
            while (!seen && cnt < EDGE_TIMEOUT) begin
                @(negedge clk_i);
                seen = fc_interrupts_o[soc_periph_pkg::IRQ_REF_EDGE];
                cnt++;
            end
            assert (seen) else begin
                $display("irq_ref_edge: no pulse on bit 14 within %0d cycles", EDGE_TIMEOUT);
                err_cnt++;
            end
            @(negedge clk_i);
            check_eq("irq_ref_edge", "vector after pulse", 32'h0, fc_interrupts_o);
        end
        end_test("irq_ref_edge");

        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
soc_periph_pkg.sv
apb_periph_demux.sv
soc_ctrl_regs.sv
fc_timer.sv
fc_irq_map.sv
soc_peripherals.sv
tb_soc_peripherals.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_soc_peripherals \
    -f compile.f

output=$(./obj_dir/Vtb_soc_peripherals)
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
